// File: rtl/apb_pkg.sv
package apb_pkg;

	// Byte address width shared by both buses
	localparam int addr_bits = 8;

	typedef logic [addr_bits-1:0] apb_addr_t;
	typedef logic [31:0] half_t;
	typedef logic [63:0] full_t;

	// One posted write, address above data
	typedef struct packed {
		apb_addr_t addr;
		full_t data;
	} wb_entry_t;

	// Lower half lands one word above the entry address
	localparam apb_addr_t word_step = apb_addr_t'(4);

	// Converter states, setup and access for each downstream transfer
	typedef enum logic [2:0] {
		idle,
		hi_setup,
		hi_access,
		lo_setup,
		lo_access,
		rd_setup,
		rd_access
	} wb_state_t;

endpackage

// File: rtl/apb_if.sv
`timescale 1ns/1ps

interface apb_if import apb_pkg::*; #(
	parameter int data_width = 32
) ();

	// Requester side
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [data_width-1:0] pwdata;

	// Completer side
	logic pready;
	logic [data_width-1:0] prdata;

	modport requester (
		output paddr, psel, penable, pwrite, pwdata,
		input pready, prdata
	);

	modport completer (
		input paddr, psel, penable, pwrite, pwdata,
		output pready, prdata
	);

	// Passive view for checkers
	modport monitor (
		input paddr, psel, penable, pwrite, pwdata, pready, prdata
	);

endinterface

// File: rtl/wb_fifo.sv
`timescale 1ns/1ps

module wb_fifo import apb_pkg::*; #(
	parameter int fifo_depth = 8
) (
	input logic down,
	input logic reset,
	input logic push,
	input wb_entry_t push_data,
	input logic pop,
	output wb_entry_t head,
	output logic empty,
	output logic full
);

	// Depth is a power of two, so pointers wrap on their own
	localparam int ptr_bits = $clog2(fifo_depth);
	localparam int cnt_bits = $clog2(fifo_depth + 1);

	wb_entry_t store [fifo_depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [cnt_bits-1:0] count;
	logic do_push;
	logic do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == cnt_bits'(fifo_depth));

	// Show-ahead, oldest entry always on head
	assign head = store[rd_ptr];

	always_ff @(posedge down) begin
		if (do_push)
			store[wr_ptr] <= push_data;
	end

	always_ff @(posedge down) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy only moves when one side acts alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/apb_write_buffer.sv
`timescale 1ns/1ps

module apb_write_buffer import apb_pkg::*; #(
	parameter int fifo_depth = 8
) (
	input logic down,
	input logic reset,
	apb_if.completer up,
	apb_if.requester mem
);

	wb_state_t state;
	wb_state_t state_next;

	logic wr_req;
	logic rd_req;
	logic rd_done;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_full;
	wb_entry_t fifo_in;
	wb_entry_t fifo_head;
	logic [addr_bits-1:0] lo_addr;

	////////////////////////////////////////////////////////////////////////////
	// Posted write FIFO
	////////////////////////////////////////////////////////////////////////////

	assign fifo_in = '{addr: up.paddr, data: up.pwdata};

	// Entry retires once its second half is in memory
	assign fifo_pop = (state == lo_access) && mem.pready;

	wb_fifo #(
		.fifo_depth(fifo_depth)
	) fifo_i (
		.down(down),
		.reset(reset),
		.push(fifo_push),
		.push_data(fifo_in),
		.pop(fifo_pop),
		.head(fifo_head),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	////////////////////////////////////////////////////////////////////////////
	// Upstream completer
	////////////////////////////////////////////////////////////////////////////

	// Only access-phase requests count
	assign wr_req = up.psel && up.penable && up.pwrite;
	assign rd_req = up.psel && up.penable && !up.pwrite;

	// Writes complete as soon as there is room
	assign fifo_push = wr_req && !fifo_full;

	// Read finishes together with its downstream read
	assign rd_done = rd_req && (state == rd_access) && mem.pready;

	assign up.pready = fifo_push || rd_done;
	// Narrow read, upper half tied to zero
	assign up.prdata = {half_t'('0), mem.prdata};

	////////////////////////////////////////////////////////////////////////////
	// Downstream converter FSM
	////////////////////////////////////////////////////////////////////////////

	assign lo_addr = fifo_head.addr + word_step;

	always_comb begin
		state_next = state;
		unique case (state)
			idle: begin
				// Drain writes first so a read sees them
				if (!fifo_empty)
					state_next = hi_setup;
				else if (rd_req)
					state_next = rd_setup;
			end
			hi_setup:
				state_next = hi_access;
			hi_access:
				if (mem.pready)
					state_next = lo_setup;
			lo_setup:
				state_next = lo_access;
			lo_access:
				if (mem.pready)
					state_next = idle;
			rd_setup:
				state_next = rd_access;
			rd_access:
				if (mem.pready)
					state_next = idle;
			default:
				state_next = idle;
		endcase
	end

	always_ff @(posedge down) begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	// Bus outputs decoded from state, idle keeps the bus quiet
	always_comb begin
		mem.paddr = '0;
		mem.psel = 1'b0;
		mem.penable = 1'b0;
		mem.pwrite = 1'b0;
		mem.pwdata = '0;
		unique case (state)
			hi_setup, hi_access: begin
				mem.paddr = fifo_head.addr;
				mem.psel = 1'b1;
				mem.penable = (state == hi_access);
				mem.pwrite = 1'b1;
				mem.pwdata = fifo_head.data[63:32];
			end
			lo_setup, lo_access: begin
				mem.paddr = lo_addr;
				mem.psel = 1'b1;
				mem.penable = (state == lo_access);
				mem.pwrite = 1'b1;
				mem.pwdata = fifo_head.data[31:0];
			end
			rd_setup, rd_access: begin
				// Upstream holds its address while stalled
				mem.paddr = up.paddr;
				mem.psel = 1'b1;
				mem.penable = (state == rd_access);
			end
			default: begin
			end
		endcase
	end

endmodule

// File: rtl/apb_word_ram.sv
`timescale 1ns/1ps

module apb_word_ram import apb_pkg::*; #(
	parameter int wait_states = 2,
	parameter int mem_words = 64
) (
	input logic down,
	input logic reset,
	apb_if.completer bus
);

	localparam int idx_bits = (mem_words > 1) ? $clog2(mem_words) : 1;
	localparam int cnt_bits = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

	half_t words [mem_words];
	logic [idx_bits-1:0] word_idx;
	logic [cnt_bits-1:0] wait_cnt;
	logic access;

	assign access = bus.psel && bus.penable;

	// Word index above the byte lane, wrapping at mem_words
	assign word_idx = idx_bits'(int'(bus.paddr[addr_bits-1:2]) % mem_words);

	// Ready after a fixed number of access cycles
	assign bus.pready = access && (wait_cnt == cnt_bits'(wait_states));
	assign bus.prdata = words[word_idx];

	always_ff @(posedge down) begin
		if (reset) begin
			wait_cnt <= '0;
			for (int i = 0; i < mem_words; i++)
				words[i] <= '0;
		end else begin
			// Counter restarts for every transfer
			if (bus.pready || !access)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 1'b1;
			// Write commits on the ready clock
			if (bus.pready && bus.pwrite)
				words[word_idx] <= bus.pwdata;
		end
	end

endmodule

// File: rtl/apb_wb_top.sv
`timescale 1ns/1ps

module apb_wb_top import apb_pkg::*; #(
	parameter int fifo_depth = 8,
	parameter int wait_states = 2,
	parameter int mem_words = 64
) (
	input logic down,
	input logic reset,
	input apb_addr_t up_paddr,
	input logic up_psel,
	input logic up_penable,
	input logic up_pwrite,
	input full_t up_pwdata,
	output logic up_pready,
	output full_t up_prdata
);

	// Wide requester bus and narrow memory bus
	apb_if #(.data_width(64)) up_bus ();
	apb_if #(.data_width(32)) mem_bus ();

	assign up_bus.paddr = up_paddr;
	assign up_bus.psel = up_psel;
	assign up_bus.penable = up_penable;
	assign up_bus.pwrite = up_pwrite;
	assign up_bus.pwdata = up_pwdata;
	assign up_pready = up_bus.pready;
	assign up_prdata = up_bus.prdata;

	apb_write_buffer #(
		.fifo_depth(fifo_depth)
	) buffer_i (
		.down(down),
		.reset(reset),
		.up(up_bus.completer),
		.mem(mem_bus.requester)
	);

	apb_word_ram #(
		.wait_states(wait_states),
		.mem_words(mem_words)
	) ram_i (
		.down(down),
		.reset(reset),
		.bus(mem_bus.completer)
	);

endmodule

// File: verif/apb_wb_checker.sv
`timescale 1ns/1ps

module apb_wb_checker import apb_pkg::*; (
	input logic down,
	input logic reset,
	input apb_addr_t up_paddr,
	input logic up_psel,
	input logic up_penable,
	input logic up_pwrite,
	input full_t up_pwdata,
	input logic up_pready,
	input full_t up_prdata,
	output int errors,
	output int writes,
	output int reads
);

	// Reference word memory, one entry per 32-bit word
	half_t ref_mem [64];
	apb_addr_t lo_addr;
	full_t expected;
	logic done;

	// Transfer completes on an access clock with pready
	assign done = up_psel && up_penable && up_pready;

	initial begin
		errors = 0;
		writes = 0;
		reads = 0;
	end

	always @(posedge down) begin
		if (reset) begin
			for (int i = 0; i < 64; i++)
				ref_mem[i] = '0;
			if (up_pready !== 1'b0) begin
				$display("FAILED up_pready during reset: got %h, expected %h",
					up_pready, 1'b0);
				errors = errors + 1;
			end
		end else if (done && up_pwrite) begin
			// Upper half at the address, lower half one word above
			lo_addr = up_paddr + word_step;
			ref_mem[up_paddr[addr_bits-1:2]] = up_pwdata[63:32];
			ref_mem[lo_addr[addr_bits-1:2]] = up_pwdata[31:0];
			writes = writes + 1;
		end else if (done) begin
			// Narrow read, zero above
			expected = {32'h0, ref_mem[up_paddr[addr_bits-1:2]]};
			if (up_prdata !== expected) begin
				$display("FAILED up_prdata at addr %h: got %h, expected %h",
					up_paddr, up_prdata, expected);
				errors = errors + 1;
			end
			reads = reads + 1;
		end
	end

endmodule

// File: verif/apb_wb_assert.sv
`timescale 1ns/1ps

module apb_wb_assert import apb_pkg::*; (
	input logic down,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pwrite,
	input apb_addr_t paddr,
	input half_t pwdata
);

	// Bus quiet on the clock after reset
	quiet_after_reset: assert property (@(posedge down) reset |=> (!psel && !penable))
		else $error("downstream bus active right after reset");

	enable_with_select: assert property (@(posedge down) disable iff (reset)
		penable |-> psel)
		else $error("penable high without psel");

	// Access only after a setup cycle
	setup_before_access: assert property (@(posedge down) disable iff (reset)
		$rose(penable) |-> $past(psel && !penable))
		else $error("penable rose without a setup cycle");

	// Request fields frozen until pready
	hold_until_ready: assert property (@(posedge down) disable iff (reset)
		(psel && !pready) |=> (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
		else $error("downstream request changed before pready");

endmodule

bind apb_write_buffer apb_wb_assert assert_i (
	.down(down),
	.reset(reset),
	.psel(mem.psel),
	.penable(mem.penable),
	.pready(mem.pready),
	.pwrite(mem.pwrite),
	.paddr(mem.paddr),
	.pwdata(mem.pwdata)
);

// File: verif/apb_wb_tb.sv
`timescale 1ns/1ps

module apb_wb_tb import apb_pkg::*; ();

	localparam int n_random = 200;
	// Generous budget per transfer, drain included
	localparam int cycle_limit = n_random * 40;

	logic down;
	logic reset;
	apb_addr_t up_paddr;
	logic up_psel;
	logic up_penable;
	logic up_pwrite;
	full_t up_pwdata;
	logic up_pready;
	full_t up_prdata;

	int errors;
	int writes;
	int reads;
	int cycles;
	logic [31:0] lfsr;
	logic [63:0] pick;
	apb_addr_t addr;
	full_t data;

	apb_wb_top dut_i (.*);

	apb_wb_checker checker_i (.*);

	////////////////////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	// Setup now, access next negedge, hold until pready
	task automatic apb_xfer(input apb_addr_t a, input logic wr, input full_t d);
		up_paddr = a;
		up_pwrite = wr;
		up_pwdata = wr ? d : '0;
		up_psel = 1'b1;
		up_penable = 1'b0;
		@(negedge down);
		up_penable = 1'b1;
		do
			@(posedge down);
		while (!up_pready);
		@(negedge down);
		up_psel = 1'b0;
		up_penable = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////////////////////////////////////////

	initial begin
		down = 1'b0;
		forever #10 down = ~down;
	end

	initial
		cycles = 0;

	always @(posedge down) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		lfsr = 32'h6ba0_66c3;
		reset = 1'b1;
		up_paddr = '0;
		up_psel = 1'b0;
		up_penable = 1'b0;
		up_pwrite = 1'b0;
		up_pwdata = '0;
		repeat (2) @(negedge down);
		reset = 1'b0;
		// Fresh memory reads as zero
		apb_xfer(8'h00, 1'b0, '0);
		apb_xfer(8'hfc, 1'b0, '0);
		pick = take_bits(6);
		apb_xfer({pick[5:0], 2'b00}, 1'b0, '0);
		// Write then read both halves back
		repeat (4) begin
			pick = take_bits(5);
			addr = {pick[4:0], 3'b000};
			data = take_bits(64);
			apb_xfer(addr, 1'b1, data);
			apb_xfer(addr, 1'b0, '0);
			apb_xfer(addr + word_step, 1'b0, '0);
		end
		// Short burst to one address, read straight after
		repeat (4)
			apb_xfer(8'h40, 1'b1, take_bits(64));
		apb_xfer(8'h40, 1'b0, '0);
		apb_xfer(8'h44, 1'b0, '0);
		// Gapless burst past the FIFO depth
		for (int i = 0; i < 12; i++)
			apb_xfer(apb_addr_t'(8'h80 + 8 * i), 1'b1, take_bits(64));
		for (int i = 0; i < 24; i++)
			apb_xfer(apb_addr_t'(8'h80 + 4 * i), 1'b0, '0);
		// Mixed random traffic
		repeat (n_random) begin
			if (take_bits(1) == 1) begin
				pick = take_bits(5);
				apb_xfer({pick[4:0], 3'b000}, 1'b1, take_bits(64));
			end else begin
				pick = take_bits(6);
				apb_xfer({pick[5:0], 2'b00}, 1'b0, '0);
			end
			repeat (int'(take_bits(2)))
				@(negedge down);
		end
		$display("Done: %0d writes, %0d reads, %0d errors", writes, reads, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: apb_wb_top.f
rtl/apb_pkg.sv
rtl/apb_if.sv
rtl/wb_fifo.sv
rtl/apb_write_buffer.sv
rtl/apb_word_ram.sv
rtl/apb_wb_top.sv
verif/apb_wb_checker.sv
verif/apb_wb_assert.sv
verif/apb_wb_tb.sv
